//--- common/biriq_config.svh
// Widths and bit positions assume RV32 machine mode only, with three interrupt lines
`ifndef BIRIQ_CONFIG_SVH
`define BIRIQ_CONFIG_SVH

// Data word and CSR address widths
`define CSR_XLEN 32
`define CSR_ADDR_W 12

// Requests the core may have in flight on the CSR channel
`define CSR_CREDITS 2

// Saved PC is word aligned, so the two low bits are not stored
`define EPC_W 30

// Software, timer and external lines
`define IRQ_W 3

// mstatus fields
`define MSTATUS_MIE_BIT 3
`define MSTATUS_MPIE_BIT 7

// mip and mie share one layout
`define MIP_MSIP_BIT 3
`define MIP_MTIP_BIT 7
`define MIP_MEIP_BIT 11

// mtvec mode field sits in the low bits
`define MTVEC_MODE_W 2

`endif

//--- common/csr_pkg.sv
// Only the machine-mode CSRs listed in csr_addr_e exist; any other address is unimplemented
`default_nettype none

`include "biriq_config.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_data_t;

  // Implemented CSRs, all in the machine-mode address range
  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MINSTRET  = 12'hB02,
    CSR_MINSTRETH = 12'hB82
  } csr_addr_e;

  // Follows the low two bits of the RISC-V CSR funct3 field
  typedef enum logic [1:0] {
    CSR_OP_RSVD  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic [`CSR_XLEN-`MTVEC_MODE_W-1:0] base;
    logic [`MTVEC_MODE_W-1:0]           mode;
  } mtvec_fields_t;

  // mtvec seen either as a plain word or split into base and mode
  typedef union packed {
    csr_data_t     raw;
    mtvec_fields_t tvec;
  } csr_word_u;

endpackage

`default_nettype wire

//--- common/trap_pkg.sv
// Interrupt vector order is software, timer, external from bit 0 upward
`default_nettype none

`include "biriq_config.svh"

package trap_pkg;

  typedef logic [`EPC_W-1:0] epc_t;
  typedef logic [3:0] cause_code_t;
  typedef logic [`IRQ_W-1:0] irq_vec_t;

  localparam int IRQ_SOFT = 0;
  localparam int IRQ_TIMER = 1;
  localparam int IRQ_EXT = 2;

  // Spread an interrupt vector onto the mip and mie word layout
  function automatic logic [`CSR_XLEN-1:0] irq_to_word(irq_vec_t v);
    logic [`CSR_XLEN-1:0] w;
    w = '0;
    w[`MIP_MSIP_BIT] = v[IRQ_SOFT];
    w[`MIP_MTIP_BIT] = v[IRQ_TIMER];
    w[`MIP_MEIP_BIT] = v[IRQ_EXT];
    return w;
  endfunction

  function automatic irq_vec_t word_to_irq(logic [`CSR_XLEN-1:0] w);
    return {w[`MIP_MEIP_BIT], w[`MIP_MTIP_BIT], w[`MIP_MSIP_BIT]};
  endfunction

endpackage

`default_nettype wire

//--- csrfile/csr_access.sv
// Requester must hold a credit per request; responses land exactly one cycle after acceptance
`timescale 1ns/1ns
`default_nettype none

`include "biriq_config.svh"

module csr_access
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  wire             cpu_clock_i,
  input  wire             rst_i,
  input  wire             csr_valid_i,
  input  wire csr_addr_e  csr_address_i,
  input  wire csr_op_e    csr_opcode_i,
  input  wire             csr_wr_en_i,
  input  wire csr_data_t  csr_data_i,
  input  wire csr_data_t  rdata_trap_i,
  input  wire csr_data_t  rdata_cnt_i,
  input  wire csr_data_t  rdata_cnth_i,
  output logic            csr_done_o,
  output logic            csr_excp_o,
  output csr_data_t       csr_data_o,
  output logic            csr_credit_o,
  output logic            wr_trap_o,
  output logic            wr_cnt_o,
  output logic            wr_hi_o,
  output csr_addr_e       wr_addr_o,
  output csr_data_t       wr_value_o,
  output irq_vec_t        mie_bits_o,
  output csr_data_t       mtvec_o
);

  localparam int credit_w = $clog2(`CSR_CREDITS + 1) + 1;

  logic [credit_w-1:0] init_cnt_q;
  logic [credit_w-1:0] held_q;
  logic                init_busy;
  irq_vec_t            mie_q;
  csr_word_u           mtvec_q;
  csr_data_t           mscratch_q;
  csr_data_t           old_value;
  csr_data_t           new_value;
  csr_word_u           tvec_legal;
  logic                implemented;
  logic                excp;
  logic                do_write;

  // Old value of the addressed register, from here or from its owner
  always_comb begin
    implemented = 1'b1;
    old_value = '0;
    case (csr_address_i)
      CSR_MSTATUS, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP: old_value = rdata_trap_i;
      CSR_MIE:       old_value = irq_to_word(mie_q);
      CSR_MTVEC:     old_value = mtvec_q.raw;
      CSR_MSCRATCH:  old_value = mscratch_q;
      CSR_MINSTRET:  old_value = rdata_cnt_i;
      CSR_MINSTRETH: old_value = rdata_cnth_i;
      default:       implemented = 1'b0;
    endcase
  end

  always_comb begin
    case (csr_opcode_i)
      CSR_OP_SET:   new_value = old_value | csr_data_i;
      CSR_OP_CLEAR: new_value = old_value & ~csr_data_i;
      default:      new_value = csr_data_i;
    endcase
  end

  // mip is read only, so a write attempt traps instead of being ignored
  assign excp = !implemented || (csr_opcode_i == CSR_OP_RSVD) ||
                ((csr_address_i == CSR_MIP) && csr_wr_en_i);
  assign do_write = csr_valid_i && csr_wr_en_i && !excp;

  assign wr_trap_o = do_write && (csr_address_i inside {CSR_MSTATUS, CSR_MEPC,
                                                        CSR_MCAUSE, CSR_MTVAL});
  assign wr_cnt_o = do_write && (csr_address_i inside {CSR_MINSTRET, CSR_MINSTRETH});
  assign wr_hi_o = (csr_address_i == CSR_MINSTRETH);
  assign wr_addr_o = csr_address_i;
  assign wr_value_o = new_value;

  // Modes 2 and 3 are reserved and fall back to direct mode
  always_comb begin
    tvec_legal.raw = new_value;
    if (tvec_legal.tvec.mode[1]) begin
      tvec_legal.tvec.mode = '0;
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      mie_q <= '0;
      mtvec_q <= '0;
      mscratch_q <= '0;
    end else if (do_write) begin
      case (csr_address_i)
        CSR_MIE:      mie_q <= word_to_irq(new_value);
        CSR_MTVEC:    mtvec_q <= tvec_legal;
        CSR_MSCRATCH: mscratch_q <= new_value;
        default:      ;
      endcase
    end
  end

  assign init_busy = (init_cnt_q < credit_w'(`CSR_CREDITS));

  // The initial credit run pauses while a response already returns a credit
  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      csr_done_o <= 1'b0;
      csr_excp_o <= 1'b0;
      csr_credit_o <= 1'b0;
      csr_data_o <= '0;
      init_cnt_q <= '0;
    end else begin
      csr_done_o <= csr_valid_i;
      csr_excp_o <= csr_valid_i && excp;
      csr_credit_o <= csr_valid_i || init_busy;
      if (csr_valid_i) begin
        csr_data_o <= old_value;
      end
      if (init_busy && !csr_valid_i) begin
        init_cnt_q <= init_cnt_q + 1'b1;
      end
    end
  end

  // Mirror of the credits the requester holds
  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      held_q <= '0;
    end else if (csr_credit_o && !csr_valid_i) begin
      held_q <= held_q + 1'b1;
    end else if (!csr_credit_o && csr_valid_i) begin
      held_q <= held_q - 1'b1;
    end
  end

  assign mie_bits_o = mie_q;
  assign mtvec_o = mtvec_q.raw;

  a_credit_held: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    csr_valid_i |-> (held_q != '0))
    else $error("CSR request issued without a credit");

  a_opcode_known: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    csr_valid_i |-> !$isunknown(csr_opcode_i))
    else $error("CSR opcode unknown on a valid request");

endmodule

`default_nettype wire

//--- csrfile/trap_ctrl.sv
// Trap, interrupt and mret inputs must be one-hot or idle; mip is read only
`timescale 1ns/1ns
`default_nettype none

`include "biriq_config.svh"

module trap_ctrl
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  wire               cpu_clock_i,
  input  wire               rst_i,
  input  wire               take_exception_i,
  input  wire               take_interrupt_i,
  input  wire               mret_i,
  input  wire epc_t         epc_i,
  input  wire csr_data_t    mtval_i,
  input  wire cause_code_t  mcause_i,
  input  wire irq_vec_t     ext_int_i,
  input  wire irq_vec_t     mie_bits_i,
  input  wire               wr_trap_i,
  input  wire csr_addr_e    wr_addr_i,
  input  wire csr_data_t    wr_value_i,
  output csr_data_t         rdata_trap_o,
  output epc_t              mepc_o,
  output logic              mie_o,
  output logic              int_pending_o,
  output irq_vec_t          mip_o
);

  logic        trap_take;
  irq_vec_t    irq_meta_q;
  irq_vec_t    irq_sync_q;
  logic        mie_q;
  logic        mpie_q;
  epc_t        mepc_q;
  logic        mcause_int_q;
  cause_code_t mcause_code_q;
  csr_data_t   mtval_q;

  assign trap_take = take_exception_i | take_interrupt_i;

  // Two-stage synchronizer for the asynchronous interrupt lines
  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      irq_meta_q <= '0;
      irq_sync_q <= '0;
    end else begin
      irq_meta_q <= ext_int_i;
      irq_sync_q <= irq_meta_q;
    end
  end

  // Trap beats mret, and both beat a software write to mstatus
  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      mie_q <= 1'b0;
      mpie_q <= 1'b0;
    end else if (trap_take) begin
      mpie_q <= mie_q;
      mie_q <= 1'b0;
    end else if (mret_i) begin
      mie_q <= mpie_q;
      mpie_q <= 1'b1;
    end else if (wr_trap_i && (wr_addr_i == CSR_MSTATUS)) begin
      mie_q <= wr_value_i[`MSTATUS_MIE_BIT];
      mpie_q <= wr_value_i[`MSTATUS_MPIE_BIT];
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      mepc_q <= '0;
      mcause_int_q <= 1'b0;
      mcause_code_q <= '0;
      mtval_q <= '0;
    end else if (trap_take) begin
      mepc_q <= epc_i;
      mcause_int_q <= take_interrupt_i;
      mcause_code_q <= mcause_i;
      mtval_q <= take_exception_i ? mtval_i : '0;
    end else if (wr_trap_i) begin
      case (wr_addr_i)
        CSR_MEPC: mepc_q <= wr_value_i[`CSR_XLEN-1 -: `EPC_W];
        CSR_MCAUSE: begin
          mcause_int_q <= wr_value_i[`CSR_XLEN-1];
          mcause_code_q <= wr_value_i[$bits(cause_code_t)-1:0];
        end
        CSR_MTVAL: mtval_q <= wr_value_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    rdata_trap_o = '0;
    case (wr_addr_i)
      CSR_MSTATUS: begin
        rdata_trap_o[`MSTATUS_MIE_BIT] = mie_q;
        rdata_trap_o[`MSTATUS_MPIE_BIT] = mpie_q;
      end
      CSR_MEPC:   rdata_trap_o = {mepc_q, {(`CSR_XLEN-`EPC_W){1'b0}}};
      CSR_MCAUSE: rdata_trap_o = {mcause_int_q, {(`CSR_XLEN-5){1'b0}}, mcause_code_q};
      CSR_MTVAL:  rdata_trap_o = mtval_q;
      CSR_MIP:    rdata_trap_o = irq_to_word(irq_sync_q);
      default:    ;
    endcase
  end

  assign mepc_o = mepc_q;
  assign mie_o = mie_q;
  assign mip_o = irq_sync_q;
  assign int_pending_o = mie_q && |(irq_sync_q & mie_bits_i);

  a_trap_onehot: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    $onehot0({take_exception_i, take_interrupt_i, mret_i}))
    else $error("More than one of exception, interrupt and mret raised");

endmodule

`default_nettype wire

//--- csrfile/retire_counter.sv
// A write to either half drops that cycle's commit increment entirely
`timescale 1ns/1ns
`default_nettype none

`include "biriq_config.svh"

module retire_counter
  import csr_pkg::*;
(
  input  wire            cpu_clock_i,
  input  wire            rst_i,
  input  wire            commit0_i,
  input  wire            commit1_i,
  input  wire            wr_cnt_i,
  input  wire            wr_hi_i,
  input  wire csr_data_t wr_value_i,
  output csr_data_t      rdata_lo_o,
  output csr_data_t      rdata_hi_o
);

  localparam int cnt_w = 2 * `CSR_XLEN;

  logic [1:0]       inc;
  logic [cnt_w-1:0] count_q;
  logic [cnt_w-1:0] count_next;

  // Both commit ports may retire in the same cycle
  assign inc = {1'b0, commit0_i} + {1'b0, commit1_i};

  // Full 64-bit add so the carry reaches minstreth
  assign count_next = count_q + {{(cnt_w-2){1'b0}}, inc};

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (wr_cnt_i) begin
      if (wr_hi_i) begin
        count_q[cnt_w-1:`CSR_XLEN] <= wr_value_i;
      end else begin
        count_q[`CSR_XLEN-1:0] <= wr_value_i;
      end
    end else begin
      count_q <= count_next;
    end
  end

  assign rdata_lo_o = count_q[`CSR_XLEN-1:0];
  assign rdata_hi_o = count_q[cnt_w-1:`CSR_XLEN];

endmodule

`default_nettype wire

//--- hdl/machine_csr_unit.sv
// Machine mode only; the core must obey the credit protocol and one-hot trap inputs
`timescale 1ns/1ns
`default_nettype none

module machine_csr_unit
  import csr_pkg::*;
  import trap_pkg::*;
(
  input  wire               cpu_clock_i,
  input  wire               rst_i,
  // CSR request channel
  input  wire               csr_valid_i,
  input  wire csr_addr_e    csr_address_i,
  input  wire csr_op_e      csr_opcode_i,
  input  wire               csr_wr_en_i,
  input  wire csr_data_t    csr_data_i,
  output logic              csr_done_o,
  output logic              csr_excp_o,
  output csr_data_t         csr_data_o,
  output logic              csr_credit_o,
  // Trap interface from the commit stage
  input  wire               take_exception_i,
  input  wire               take_interrupt_i,
  input  wire               mret_i,
  input  wire epc_t         epc_i,
  input  wire csr_data_t    mtval_i,
  input  wire cause_code_t  mcause_i,
  input  wire irq_vec_t     ext_int_i,
  input  wire               commit0_i,
  input  wire               commit1_i,
  output irq_vec_t          mip_o,
  output logic              mie_o,
  output logic              int_pending_o,
  output epc_t              mepc_o,
  output csr_data_t         mtvec_o
);

  logic      wr_trap;
  logic      wr_cnt;
  logic      wr_hi;
  csr_addr_e wr_addr;
  csr_data_t wr_value;
  irq_vec_t  mie_bits;
  csr_data_t rdata_trap;
  csr_data_t cnt_lo;
  csr_data_t cnt_hi;

  csr_access u_csr_access (
    .cpu_clock_i  (cpu_clock_i),
    .rst_i        (rst_i),
    .csr_valid_i  (csr_valid_i),
    .csr_address_i(csr_address_i),
    .csr_opcode_i (csr_opcode_i),
    .csr_wr_en_i  (csr_wr_en_i),
    .csr_data_i   (csr_data_i),
    .rdata_trap_i (rdata_trap),
    .rdata_cnt_i  (cnt_lo),
    .rdata_cnth_i (cnt_hi),
    .csr_done_o   (csr_done_o),
    .csr_excp_o   (csr_excp_o),
    .csr_data_o   (csr_data_o),
    .csr_credit_o (csr_credit_o),
    .wr_trap_o    (wr_trap),
    .wr_cnt_o     (wr_cnt),
    .wr_hi_o      (wr_hi),
    .wr_addr_o    (wr_addr),
    .wr_value_o   (wr_value),
    .mie_bits_o   (mie_bits),
    .mtvec_o      (mtvec_o)
  );

  trap_ctrl u_trap_ctrl (
    .cpu_clock_i     (cpu_clock_i),
    .rst_i           (rst_i),
    .take_exception_i(take_exception_i),
    .take_interrupt_i(take_interrupt_i),
    .mret_i          (mret_i),
    .epc_i           (epc_i),
    .mtval_i         (mtval_i),
    .mcause_i        (mcause_i),
    .ext_int_i       (ext_int_i),
    .mie_bits_i      (mie_bits),
    .wr_trap_i       (wr_trap),
    .wr_addr_i       (wr_addr),
    .wr_value_i      (wr_value),
    .rdata_trap_o    (rdata_trap),
    .mepc_o          (mepc_o),
    .mie_o           (mie_o),
    .int_pending_o   (int_pending_o),
    .mip_o           (mip_o)
  );

  retire_counter u_retire_counter (
    .cpu_clock_i(cpu_clock_i),
    .rst_i      (rst_i),
    .commit0_i  (commit0_i),
    .commit1_i  (commit1_i),
    .wr_cnt_i   (wr_cnt),
    .wr_hi_i    (wr_hi),
    .wr_value_i (wr_value),
    .rdata_lo_o (cnt_lo),
    .rdata_hi_o (cnt_hi)
  );

endmodule

`default_nettype wire

//--- verif/tb_machine_csr_unit.sv
// Run from the project root so that verif/csr_stimulus.txt is found; the first mismatch ends the run
`timescale 1ns/1ns
`default_nettype none

`include "biriq_config.svh"

module tb_machine_csr_unit
  import csr_pkg::*;
  import trap_pkg::*;
();

  logic        cpu_clock_i;
  logic        rst_i;
  logic        csr_valid_i;
  csr_addr_e   csr_address_i;
  csr_op_e     csr_opcode_i;
  logic        csr_wr_en_i;
  csr_data_t   csr_data_i;
  logic        csr_done_o;
  logic        csr_excp_o;
  csr_data_t   csr_data_o;
  logic        csr_credit_o;
  logic        take_exception_i;
  logic        take_interrupt_i;
  logic        mret_i;
  epc_t        epc_i;
  csr_data_t   mtval_i;
  cause_code_t mcause_i;
  irq_vec_t    ext_int_i;
  logic        commit0_i;
  logic        commit1_i;
  irq_vec_t    mip_o;
  logic        mie_o;
  logic        int_pending_o;
  epc_t        mepc_o;
  csr_data_t   mtvec_o;

  int credits;
  int cycle_count;
  int cycle_limit;
  int retired;

  machine_csr_unit DUT (.*);

  initial begin
    cpu_clock_i = 1'b0;
    forever #4 cpu_clock_i = ~cpu_clock_i;
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_data(input csr_data_t got, input csr_data_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_excp(input bit got, input bit exp);
    if (got != exp) begin
      stop_on_error($sformatf("Fail at %0t ns: csr_excp_o is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got != exp) begin
      stop_on_error($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_epc(input epc_t got, input epc_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail at %0t ns: mepc_o is %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_irq(input irq_vec_t got, input irq_vec_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail at %0t ns: mip_o is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic expect_fields(input int got, input int want);
    if (got != want) begin
      stop_on_error("A line in the stimulus file has the wrong number of fields");
    end
  endtask

  // A request may only go out while the requester holds a credit
  task automatic drive_request(input logic [31:0] addr, input logic [31:0] op, input logic wr,
                               input csr_data_t data);
    @(posedge cpu_clock_i);
    while (credits == 0) begin
      @(posedge cpu_clock_i);
    end
    credits = credits - 1;
    csr_valid_i <= 1'b1;
    csr_address_i <= csr_addr_e'(addr[`CSR_ADDR_W-1:0]);
    csr_opcode_i <= csr_op_e'(op[1:0]);
    csr_wr_en_i <= wr;
    csr_data_i <= data;
  endtask

  // The response and its credit arrive exactly one cycle after the accepting edge
  task automatic sample_response(input bit exp_excp, input csr_data_t exp_data);
    @(negedge cpu_clock_i);
    if (!csr_done_o) begin
      stop_on_error("csr_done_o did not rise one cycle after the request was accepted");
    end
    check_flag(csr_credit_o, 1'b1, "csr_credit_o");
    check_excp(csr_excp_o, exp_excp);
    check_data(csr_data_o, exp_data, "csr_data_o");
  endtask

  task automatic single_request(input logic [31:0] addr, input logic [31:0] op, input logic wr,
                                input csr_data_t data, input bit exp_excp,
                                input csr_data_t exp_data);
    drive_request(addr, op, wr, data);
    @(posedge cpu_clock_i);
    csr_valid_i <= 1'b0;
    sample_response(exp_excp, exp_data);
  endtask

  // Credits come back as one-cycle pulses, so one sample per cycle counts each once
  always @(negedge cpu_clock_i) begin
    if (!rst_i && csr_credit_o) begin
      credits = credits + 1;
      if (credits > `CSR_CREDITS) begin
        stop_on_error("The DUT returned more credits than the requester can hold");
      end
    end
  end

  always @(posedge cpu_clock_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    int fd;
    int n;
    int line_count;
    string line;
    logic [7:0] kind;
    logic [31:0] field [6];
    irq_vec_t irq_prev;

    credits = 0;
    cycle_count = 0;
    cycle_limit = 0;
    retired = 0;
    irq_prev = '0;
    rst_i = 1'b1;
    csr_valid_i = 1'b0;
    csr_address_i = CSR_MSTATUS;
    csr_opcode_i = CSR_OP_WRITE;
    csr_wr_en_i = 1'b0;
    csr_data_i = '0;
    take_exception_i = 1'b0;
    take_interrupt_i = 1'b0;
    mret_i = 1'b0;
    epc_i = '0;
    mtval_i = '0;
    mcause_i = '0;
    ext_int_i = '0;
    commit0_i = 1'b0;
    commit1_i = 1'b0;

    // The timeout scales with the length of the stimulus
    fd = $fopen("verif/csr_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open verif/csr_stimulus.txt");
    end
    line_count = 0;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        line_count++;
      end
    end
    $fclose(fd);
    cycle_limit = 20 * line_count + 100;

    repeat (3) @(posedge cpu_clock_i);
    rst_i <= 1'b0;

    fd = $fopen("verif/csr_stimulus.txt", "r");
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": n = $fgets(line, fd);
        "R": begin
          n = $fscanf(fd, "%h %h %h %h %h %h", field[0], field[1], field[2], field[3],
                      field[4], field[5]);
          expect_fields(n, 6);
          single_request(field[0], field[1], field[2][0], field[3], field[4][0], field[5]);
          // Reads of mtvec and mstatus are also visible on the side outputs
          if (!field[2][0] && !field[4][0]) begin
            if (field[0][`CSR_ADDR_W-1:0] == CSR_MTVEC) begin
              check_data(mtvec_o, field[5], "mtvec_o");
            end
            if (field[0][`CSR_ADDR_W-1:0] == CSR_MSTATUS) begin
              check_flag(mie_o, field[5][`MSTATUS_MIE_BIT], "mie_o");
            end
          end
        end
        "E": begin
          n = $fscanf(fd, "%h %h %h", field[0], field[1], field[2]);
          expect_fields(n, 3);
          @(posedge cpu_clock_i);
          take_exception_i <= 1'b1;
          epc_i <= field[0][`EPC_W-1:0];
          mtval_i <= field[1];
          mcause_i <= field[2][3:0];
          @(posedge cpu_clock_i);
          take_exception_i <= 1'b0;
          @(negedge cpu_clock_i);
          check_epc(mepc_o, field[0][`EPC_W-1:0]);
          check_flag(mie_o, 1'b0, "mie_o");
        end
        "M": begin
          @(posedge cpu_clock_i);
          mret_i <= 1'b1;
          @(posedge cpu_clock_i);
          mret_i <= 1'b0;
        end
        "X": begin
          n = $fscanf(fd, "%h %h", field[0], field[1]);
          expect_fields(n, 2);
          @(posedge cpu_clock_i);
          ext_int_i <= field[0][`IRQ_W-1:0];
          // After the first synchronizer stage mip still shows the previous lines
          @(posedge cpu_clock_i);
          @(negedge cpu_clock_i);
          check_irq(mip_o, irq_prev);
          @(posedge cpu_clock_i);
          @(negedge cpu_clock_i);
          check_irq(mip_o, field[0][`IRQ_W-1:0]);
          check_flag(int_pending_o, field[1][0], "int_pending_o");
          irq_prev = field[0][`IRQ_W-1:0];
        end
        "C": begin
          n = $fscanf(fd, "%h %h", field[0], field[1]);
          expect_fields(n, 2);
          for (int i = 0; i < field[0]; i++) begin
            @(posedge cpu_clock_i);
            commit0_i <= field[1][2*i];
            commit1_i <= field[1][2*i+1];
            retired = retired + field[1][2*i] + field[1][2*i+1];
          end
          @(posedge cpu_clock_i);
          commit0_i <= 1'b0;
          commit1_i <= 1'b0;
        end
        "N": single_request(32'hb02, 32'h1, 1'b0, '0, 1'b0, csr_data_t'(retired));
        "B": begin
          n = $fscanf(fd, "%h %h %h %h", field[0], field[1], field[2], field[3]);
          expect_fields(n, 4);
          drive_request(field[0], 32'h1, 1'b0, '0);
          drive_request(field[2], 32'h1, 1'b0, '0);
          sample_response(1'b0, field[1]);
          @(posedge cpu_clock_i);
          csr_valid_i <= 1'b0;
          sample_response(1'b0, field[3]);
        end
        default: stop_on_error($sformatf("Unknown kind %c in the stimulus file", kind));
      endcase
    end
    $fclose(fd);

    repeat (2) @(negedge cpu_clock_i);
    if (credits != `CSR_CREDITS) begin
      stop_on_error($sformatf("Fail at %0t ns: credit count is %0d, expected %0d", $time,
                              credits, `CSR_CREDITS));
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/csr_stimulus.txt
# R addr op wr_en data exp_excp exp_old | E epc mtval cause | M | X irq exp_pending
# C cycles commit_pairs | N read minstret against commit sum | B addr0 exp0 addr1 exp1
R 340 1 1 12345678 0 00000000
R 340 2 1 0000f000 0 12345678
R 340 3 1 00000078 0 1234f678
R 340 1 0 00000000 0 1234f600
R 304 1 1 00000008 0 00000000
R 304 2 1 00000800 0 00000008
R 304 3 1 00000008 0 00000808
R 304 1 0 00000000 0 00000800
R 7c0 1 1 ffffffff 1 00000000
R 340 0 1 00000000 1 1234f600
R 344 1 1 ffffffff 1 00000000
R 340 1 0 00000000 0 1234f600
R 305 1 1 80000103 0 00000000
R 305 1 0 00000000 0 80000100
R 300 1 1 00000008 0 00000000
E 00000400 deadbeef 2
R 341 1 0 00000000 0 00001000
R 342 1 0 00000000 0 00000002
R 343 1 0 00000000 0 deadbeef
R 300 1 0 00000000 0 00000080
M
R 300 1 0 00000000 0 00000088
X 1 0
X 4 1
R 344 1 0 00000000 0 00000800
X 0 0
C 8 b7e4
N
R b82 1 1 00000005 0 00000000
R b82 1 0 00000000 0 00000005
N
B 340 1234f600 304 00000800

//--- sim.f
+incdir+common
common/csr_pkg.sv
common/trap_pkg.sv
csrfile/csr_access.sv
csrfile/trap_ctrl.sv
csrfile/retire_counter.sv
hdl/machine_csr_unit.sv
verif/tb_machine_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_machine_csr_unit
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
